// ==== verilog/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN = 32;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_LOAD     = 7'b0000011;
  localparam logic [6:0] OP_STORE    = 7'b0100011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;

  // funct3 of fence.i under MISC-MEM
  localparam logic [2:0] FUNCT3_FENCE_I = 3'b001;

  typedef enum logic [1:0] {
    INST_PLAIN   = 2'd0,
    INST_CONTROL = 2'd1,
    INST_LOAD    = 2'd2,
    INST_FENCE_I = 2'd3
  } inst_class_e;

  function automatic inst_class_e classify_inst(input logic [XLEN-1:0] inst);
    inst_class_e cls;
    case (inst[6:0])
      OP_JAL, OP_JALR, OP_BRANCH: cls = INST_CONTROL;
      OP_LOAD: cls = INST_LOAD;
      OP_MISC_MEM: cls = (inst[14:12] == FUNCT3_FENCE_I) ? INST_FENCE_I : INST_PLAIN;
      // stores go out without waiting on the back end
      OP_STORE: cls = INST_PLAIN;
      default: cls = INST_PLAIN;
    endcase
    return cls;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/l1i_pkg.sv ====
`default_nettype none

package l1i_pkg;

  // refill bus data and address width
  localparam int BUS_W = 32;

  typedef enum logic [2:0] {
    RF_IDLE      = 3'd0,
    RF_REQ_LO    = 3'd1,
    RF_WAIT_LO   = 3'd2,
    RF_REQ_HI    = 3'd3,
    RF_WAIT_HI   = 3'd4,
    RF_FILL_DONE = 3'd5
  } refill_state_e;

  // apb register offsets
  localparam logic [11:0] CSR_CTRL    = 12'h000;
  localparam logic [11:0] CSR_BOOT_PC = 12'h004;
  localparam logic [11:0] CSR_HITS    = 12'h008;
  localparam logic [11:0] CSR_MISSES  = 12'h00C;

  // CTRL bit positions
  localparam int CTRL_EN_BIT      = 0;
  localparam int CTRL_FLUSH_BIT   = 1;
  localparam int CTRL_RESTART_BIT = 2;
  localparam int CTRL_CLR_BIT     = 3;

endpackage

`default_nettype wire

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl import rv_isa_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic            clk,
  input  logic            rst,

  // cache side
  output logic [XLEN-1:0] fetch_pc_o,
  input  logic            hit_i,
  input  logic [XLEN-1:0] inst_i,
  output logic            flush_o,

  // decode side
  output logic            valid_o,
  input  logic            ready_i,
  output logic [XLEN-1:0] inst_o,
  output logic [XLEN-1:0] pc_o,
  output inst_class_e     class_o,

  // back end
  input  logic            pc_change_i,
  input  logic [XLEN-1:0] npc_i,
  input  logic            pc_retire_i,

  // csr restart
  input  logic            restart_i,
  input  logic [XLEN-1:0] boot_pc_i
);

  logic [XLEN-1:0] pc_q;
  logic            stall_q;
  logic            held_q;
  logic [XLEN-1:0] hold_inst_q;
  inst_class_e     cls;
  logic            xfer;

  // a word offered but not taken is kept here so a late flush cannot pull it
  assign inst_o = held_q ? hold_inst_q : inst_i;
  assign cls = classify_inst(inst_o);

  assign valid_o = (hit_i | held_q) & ~stall_q;
  assign xfer = valid_o & ready_i;

  assign fetch_pc_o = pc_q;
  assign pc_o = pc_q;
  assign class_o = cls;
  assign flush_o = xfer & (cls == INST_FENCE_I);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
      stall_q <= 1'b0;
      held_q <= 1'b0;
    end else if (restart_i) begin
      pc_q <= boot_pc_i;
      stall_q <= 1'b0;
      held_q <= 1'b0;
    end else if (stall_q) begin
      // wait for the back end to resolve the next pc
      if (pc_change_i) begin
        pc_q <= npc_i;
        stall_q <= 1'b0;
      end else if (pc_retire_i) begin
        pc_q <= pc_q + 32'd4;
        stall_q <= 1'b0;
      end
    end else if (xfer) begin
      held_q <= 1'b0;
      if (cls == INST_PLAIN) begin
        pc_q <= pc_q + 32'd4;
      end else begin
        stall_q <= 1'b1;
      end
    end else if (valid_o) begin
      held_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_o && !ready_i && !held_q) begin
      hold_inst_q <= inst_i;
    end
  end

  // control, load and fence.i block the next fetch
  a_stall_after_hazard: assert property (
    @(posedge clk) disable iff (rst)
    xfer && (cls != INST_PLAIN) && !restart_i |=> !valid_o
  );

  // back-pressure keeps the offer intact
  a_hold_under_stall: assert property (
    @(posedge clk) disable iff (rst)
    valid_o && !ready_i && !restart_i |=> valid_o && $stable(inst_o) && $stable(pc_o)
  );

endmodule

`default_nettype wire

// ==== verilog/l1i_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1i_cache import l1i_pkg::*; #(
  parameter int unsigned L1I_INDEX_W = 2
) (
  input  logic             clk,
  input  logic             rst,

  input  logic [BUS_W-1:0] fetch_pc_i,
  input  logic             enable_i,
  input  logic             flush_i,
  output logic             hit_o,
  output logic [BUS_W-1:0] inst_o,

  // refill bus
  output logic [BUS_W-1:0] mem_araddr_o,
  output logic             mem_arvalid_o,
  output logic             mem_busy_o,
  input  logic [BUS_W-1:0] mem_rdata_i,
  input  logic             mem_rvalid_i,

  // event strobes for the counters
  output logic             hit_strobe_o,
  output logic             miss_strobe_o
);

  localparam int unsigned LINES = 2 ** L1I_INDEX_W;
  localparam int unsigned TAG_W = BUS_W - L1I_INDEX_W - 3;

  refill_state_e state;

  logic [BUS_W-1:0] data_lo [LINES];
  logic [BUS_W-1:0] data_hi [LINES];
  logic [TAG_W-1:0] tag_mem [LINES];
  logic [LINES-1:0] line_valid;

  // line address latched at miss, pc may move during refill
  logic [BUS_W-4:0] rf_line;
  logic [BUS_W-1:0] last_pc;
  logic             fresh;
  logic             seen;
  logic             flush_pend;

  logic [TAG_W-1:0]       pc_tag;
  logic [L1I_INDEX_W-1:0] pc_idx;
  logic [L1I_INDEX_W-1:0] last_idx;
  logic [TAG_W-1:0]       rf_tag;
  logic [L1I_INDEX_W-1:0] rf_idx;
  logic pc_changed, fresh_cur, seen_cur;
  logic base_hit, miss_start, lo_beat, hi_beat, flush_now;

  assign pc_tag = fetch_pc_i[BUS_W-1:L1I_INDEX_W+3];
  assign pc_idx = fetch_pc_i[L1I_INDEX_W+2:3];
  assign last_idx = last_pc[L1I_INDEX_W+2:3];
  assign rf_tag = rf_line[BUS_W-4:L1I_INDEX_W];
  assign rf_idx = rf_line[L1I_INDEX_W-1:0];

  assign pc_changed = fetch_pc_i != last_pc;
  assign fresh_cur = fresh & ~pc_changed;
  assign seen_cur = seen & ~pc_changed;

  // lookup only while the fsm is idle
  assign base_hit = (state == RF_IDLE) && line_valid[pc_idx] && (tag_mem[pc_idx] == pc_tag);
  // disabled cache serves a filled line only to the pc that missed
  assign hit_o = base_hit & (enable_i | fresh_cur);
  assign inst_o = fetch_pc_i[2] ? data_hi[pc_idx] : data_lo[pc_idx];

  assign miss_start = (state == RF_IDLE) & ~hit_o;
  assign lo_beat = mem_rvalid_i & ((state == RF_REQ_LO) | (state == RF_WAIT_LO));
  assign hi_beat = mem_rvalid_i & ((state == RF_REQ_HI) | (state == RF_WAIT_HI));
  assign flush_now = (flush_i | flush_pend) & ((state == RF_IDLE) | (state == RF_FILL_DONE));

  assign mem_arvalid_o = (state == RF_REQ_LO) | (state == RF_WAIT_LO) |
                         (state == RF_REQ_HI) | (state == RF_WAIT_HI);
  assign mem_araddr_o = {rf_line, (state == RF_REQ_HI) | (state == RF_WAIT_HI), 2'b00};
  assign mem_busy_o = state != RF_IDLE;

  assign hit_strobe_o = hit_o & enable_i & ~seen_cur;
  assign miss_strobe_o = state == RF_REQ_LO;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RF_IDLE;
    end else begin
      case (state)
        RF_IDLE: if (miss_start) state <= RF_REQ_LO;
        RF_REQ_LO, RF_WAIT_LO: state <= mem_rvalid_i ? RF_REQ_HI : RF_WAIT_LO;
        RF_REQ_HI, RF_WAIT_HI: state <= mem_rvalid_i ? RF_FILL_DONE : RF_WAIT_HI;
        RF_FILL_DONE: state <= RF_IDLE;
        default: state <= RF_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;
      flush_pend <= 1'b0;
      last_pc <= '0;
      fresh <= 1'b0;
      seen <= 1'b0;
    end else begin
      if (!enable_i && pc_changed) line_valid[last_idx] <= 1'b0;
      if (hi_beat) line_valid[rf_idx] <= 1'b1;
      // flush during refill is held until fill_done
      if (flush_now) line_valid <= '0;
      flush_pend <= (flush_pend | flush_i) & ~flush_now;
      last_pc <= fetch_pc_i;
      fresh <= (state == RF_FILL_DONE) | fresh_cur;
      seen <= seen_cur | hit_strobe_o;
    end
  end

  always_ff @(posedge clk) begin
    if (miss_start) rf_line <= fetch_pc_i[BUS_W-1:3];
    if (lo_beat) data_lo[rf_idx] <= mem_rdata_i;
    if (hi_beat) begin
      data_hi[rf_idx] <= mem_rdata_i;
      tag_mem[rf_idx] <= rf_tag;
    end
  end

  a_arvalid_hold: assert property (
    @(posedge clk) disable iff (rst)
    mem_arvalid_o && !mem_rvalid_i |=> mem_arvalid_o && $stable(mem_araddr_o)
  );

  a_state_legal: assert property (
    @(posedge clk) disable iff (rst)
    state inside {RF_IDLE, RF_REQ_LO, RF_WAIT_LO, RF_REQ_HI, RF_WAIT_HI, RF_FILL_DONE}
  );

endmodule

`default_nettype wire

// ==== verilog/fetch_csr_apb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_csr_apb import l1i_pkg::*; #(
  parameter logic [BUS_W-1:0] RESET_PC = 32'h8000_0000,
  parameter int unsigned      CNT_W = 32
) (
  input  logic             clk,
  input  logic             rst,

  input  logic             psel_i,
  input  logic             penable_i,
  input  logic             pwrite_i,
  input  logic [11:0]      paddr_i,
  input  logic [BUS_W-1:0] pwdata_i,
  output logic [BUS_W-1:0] prdata_o,
  output logic             pready_o,
  output logic             pslverr_o,

  input  logic             hit_strobe_i,
  input  logic             miss_strobe_i,
  output logic             cache_en_o,
  output logic             flush_o,
  output logic             restart_o,
  output logic [BUS_W-1:0] boot_pc_o
);

  logic [CNT_W-1:0] hits_q;
  logic [CNT_W-1:0] misses_q;
  logic access, known, counter_addr, wr_ctrl, cnt_clear;

  assign access = psel_i & penable_i;
  assign known = paddr_i inside {CSR_CTRL, CSR_BOOT_PC, CSR_HITS, CSR_MISSES};
  assign counter_addr = (paddr_i == CSR_HITS) | (paddr_i == CSR_MISSES);
  assign wr_ctrl = access & pwrite_i & (paddr_i == CSR_CTRL);
  assign cnt_clear = wr_ctrl & pwdata_i[CTRL_CLR_BIT];

  assign pready_o = 1'b1;
  assign pslverr_o = access & (~known | (pwrite_i & counter_addr));

  always_comb begin
    case (paddr_i)
      CSR_CTRL:    prdata_o = {{(BUS_W-1){1'b0}}, cache_en_o};
      CSR_BOOT_PC: prdata_o = boot_pc_o;
      CSR_HITS:    prdata_o = BUS_W'(hits_q);
      CSR_MISSES:  prdata_o = BUS_W'(misses_q);
      default:     prdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cache_en_o <= 1'b1;
      flush_o <= 1'b0;
      restart_o <= 1'b0;
      boot_pc_o <= RESET_PC;
      hits_q <= '0;
      misses_q <= '0;
    end else begin
      // flush and restart are one-cycle pulses
      flush_o <= wr_ctrl & pwdata_i[CTRL_FLUSH_BIT];
      restart_o <= wr_ctrl & pwdata_i[CTRL_RESTART_BIT];
      if (wr_ctrl) cache_en_o <= pwdata_i[CTRL_EN_BIT];
      if (access && pwrite_i && paddr_i == CSR_BOOT_PC) boot_pc_o <= pwdata_i;
      if (cnt_clear) begin
        hits_q <= '0;
        misses_q <= '0;
      end else begin
        // saturate instead of wrapping
        if (hit_strobe_i && hits_q != '1) hits_q <= hits_q + 1'b1;
        if (miss_strobe_i && misses_q != '1) misses_q <= misses_q + 1'b1;
      end
    end
  end

  a_restart_pulse: assert property (
    @(posedge clk) disable iff (rst)
    restart_o |=> !restart_o
  );

endmodule

`default_nettype wire

// ==== verilog/ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_top import rv_isa_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000,
  parameter int unsigned     L1I_INDEX_W = 2,
  parameter int unsigned     CNT_W = 32
) (
  input  logic            clk,
  input  logic            rst,

  // decode
  output logic            valid_o,
  input  logic            ready_i,
  output logic [XLEN-1:0] inst_o,
  output logic [XLEN-1:0] pc_o,
  output inst_class_e     class_o,

  // back end
  input  logic            pc_change_i,
  input  logic [XLEN-1:0] npc_i,
  input  logic            pc_retire_i,

  // memory
  output logic [XLEN-1:0] mem_araddr_o,
  output logic            mem_arvalid_o,
  output logic            mem_busy_o,
  input  logic [XLEN-1:0] mem_rdata_i,
  input  logic            mem_rvalid_i,

  // apb
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  logic [11:0]     paddr_i,
  input  logic [XLEN-1:0] pwdata_i,
  output logic [XLEN-1:0] prdata_o,
  output logic            pready_o,
  output logic            pslverr_o
);

  logic [XLEN-1:0] fetch_pc, cache_inst, boot_pc;
  logic cache_hit, fence_flush, csr_flush, cache_en, restart;
  logic hit_strobe, miss_strobe;

  fetch_ctrl #(.RESET_PC(RESET_PC)) fetch_ctrl_i (
    .clk(clk), .rst(rst),
    .fetch_pc_o(fetch_pc), .hit_i(cache_hit), .inst_i(cache_inst), .flush_o(fence_flush),
    .valid_o(valid_o), .ready_i(ready_i), .inst_o(inst_o), .pc_o(pc_o), .class_o(class_o),
    .pc_change_i(pc_change_i), .npc_i(npc_i), .pc_retire_i(pc_retire_i),
    .restart_i(restart), .boot_pc_i(boot_pc)
  );

  // fence.i and the csr flush share the cache flush
  l1i_cache #(.L1I_INDEX_W(L1I_INDEX_W)) l1i_cache_i (
    .clk(clk), .rst(rst),
    .fetch_pc_i(fetch_pc), .enable_i(cache_en), .flush_i(fence_flush | csr_flush),
    .hit_o(cache_hit), .inst_o(cache_inst),
    .mem_araddr_o(mem_araddr_o), .mem_arvalid_o(mem_arvalid_o), .mem_busy_o(mem_busy_o),
    .mem_rdata_i(mem_rdata_i), .mem_rvalid_i(mem_rvalid_i),
    .hit_strobe_o(hit_strobe), .miss_strobe_o(miss_strobe)
  );

  fetch_csr_apb #(.RESET_PC(RESET_PC), .CNT_W(CNT_W)) fetch_csr_apb_i (
    .clk(clk), .rst(rst),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
    .hit_strobe_i(hit_strobe), .miss_strobe_i(miss_strobe),
    .cache_en_o(cache_en), .flush_o(csr_flush), .restart_o(restart), .boot_pc_o(boot_pc)
  );

endmodule

`default_nettype wire

// ==== testbench/ifu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ifu_tb import rv_isa_pkg::*, l1i_pkg::*; ();

  localparam int IMG_BASE   = 16;
  localparam int TRACE_BASE = 64;
  localparam int APB_BASE   = 256;
  localparam logic [31:0] RESET_PC = 32'h8000_0000;

  logic            clk = 1'b0;
  logic            rst;
  logic            valid_o;
  logic            ready_i = 1'b0;
  logic [XLEN-1:0] inst_o;
  logic [XLEN-1:0] pc_o;
  inst_class_e     class_o;
  logic            pc_change_i;
  logic [XLEN-1:0] npc_i;
  logic            pc_retire_i;
  logic [XLEN-1:0] mem_araddr_o;
  logic            mem_arvalid_o;
  logic            mem_busy_o;
  logic [XLEN-1:0] mem_rdata_i = '0;
  logic            mem_rvalid_i = 1'b0;
  logic            psel_i;
  logic            penable_i;
  logic            pwrite_i;
  logic [11:0]     paddr_i;
  logic [XLEN-1:0] pwdata_i;
  logic [XLEN-1:0] prdata_o;
  logic            pready_o;
  logic            pslverr_o;

  logic [31:0] stim [0:511];
  integer      seed = 32'h8803c1ca;
  int          trace_len = 0;
  int          cycle_limit = 2000;
  int          cycles = 0;
  int          seen_count = 0;
  int          hazards_seen = 0;
  int          hazards_resolved = 0;
  int          mon_base;

  // memory model state
  logic        mem_pending = 1'b0;
  logic [31:0] mem_addr = '0;
  int          mem_delay = 0;

  ifu_top #(
    .RESET_PC(RESET_PC),
    .L1I_INDEX_W(2),
    .CNT_W(16)
  ) ifu_top_i (
    .clk(clk), .rst(rst),
    .valid_o(valid_o), .ready_i(ready_i), .inst_o(inst_o), .pc_o(pc_o), .class_o(class_o),
    .pc_change_i(pc_change_i), .npc_i(npc_i), .pc_retire_i(pc_retire_i),
    .mem_araddr_o(mem_araddr_o), .mem_arvalid_o(mem_arvalid_o), .mem_busy_o(mem_busy_o),
    .mem_rdata_i(mem_rdata_i), .mem_rvalid_i(mem_rvalid_i),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i),
    .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o)
  );

  always #2 clk = ~clk;

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_error($sformatf("%s mismatch: got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_class(input inst_class_e got, input inst_class_e exp);
    if (got !== exp) begin
      report_error($sformatf("class mismatch: got %0d expected %0d", got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("%s mismatch: got %b expected %b", what, got, exp));
    end
  endtask

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - RESET_PC;
    if (off < 32'd128) begin
      return stim[IMG_BASE + int'(off[6:2])];
    end
    return addr ^ 32'h5a5a_5a5a;
  endfunction

  // memory answers after 1 to 4 cycles, decode drops ready at random
  always @(posedge clk) begin
    if (rst) begin
      ready_i <= 1'b0;
      mem_rvalid_i <= 1'b0;
      mem_pending <= 1'b0;
    end else begin
      ready_i <= ($random(seed) & 3) != 0;
      mem_rvalid_i <= 1'b0;
      if (mem_arvalid_o) check_bit("mem_busy", mem_busy_o, 1'b1);
      if (mem_pending) begin
        if (mem_delay == 1) begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i <= mem_word(mem_addr);
          mem_pending <= 1'b0;
        end else begin
          mem_delay <= mem_delay - 1;
        end
      end else if (mem_arvalid_o && !mem_rvalid_i) begin
        mem_pending <= 1'b1;
        mem_addr <= mem_araddr_o;
        mem_delay <= 1 + ($random(seed) & 3);
      end
    end
  end

  // decode model, checks every transfer against the trace
  always @(posedge clk) begin
    if (!rst && valid_o && ready_i) begin
      if (seen_count >= trace_len) begin
        report_error("transfer beyond the end of the trace");
      end else if (hazards_seen != hazards_resolved) begin
        report_error("transfer while a hazard is unresolved");
      end else begin
        mon_base = TRACE_BASE + 5 * seen_count;
        check_word("pc", pc_o, stim[mon_base]);
        check_word("inst", inst_o, stim[mon_base + 1]);
        check_class(class_o, inst_class_e'(stim[mon_base + 2][1:0]));
        if (class_o != INST_PLAIN) hazards_seen <= hazards_seen + 1;
        seen_count <= seen_count + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel_i <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i <= wr;
    paddr_i <= addr;
    pwdata_i <= wdata;
    @(posedge clk);
    penable_i <= 1'b1;
    @(posedge clk);
    check_bit("pready", pready_o, 1'b1);
    rdata = prdata_o;
    err = pslverr_o;
    psel_i <= 1'b0;
    penable_i <= 1'b0;
  endtask

  // flags: bit0 write, bit1 expect pslverr, bit2 compare read data
  task automatic run_apb_step(input int idx);
    int          b;
    logic [31:0] flags;
    logic [31:0] rdata;
    logic        err;
    b = APB_BASE + 4 * idx;
    flags = stim[b];
    apb_access(flags[0], stim[b + 1][11:0], stim[b + 2], rdata, err);
    check_bit("pslverr", err, flags[1]);
    if (flags[2]) check_word("prdata", rdata, stim[b + 3]);
  endtask

  initial begin
    int          e;
    int          k;
    int          base;
    int          apb_ptr;
    int          resolved_local;
    logic [31:0] res;
    logic [31:0] rd;
    logic        rd_err;
    rst = 1'b1;
    pc_change_i = 1'b0;
    npc_i = '0;
    pc_retire_i = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    for (int i = 0; i < 512; i++) begin
      stim[i] = {16'(i), ~16'(i)};
    end
    $readmemh("testbench/ifu_stimulus.mem", stim);
    trace_len = int'(stim[0]);
    cycle_limit = 40 * trace_len + 2000;
    apb_ptr = 0;
    resolved_local = 0;

    repeat (8) @(posedge clk);
    check_bit("valid after reset", valid_o, 1'b0);
    check_bit("arvalid after reset", mem_arvalid_o, 1'b0);
    check_bit("busy after reset", mem_busy_o, 1'b0);
    check_word("pc after reset", pc_o, RESET_PC);
    rst <= 1'b0;

    // cache comes up enabled with the boot pc at the reset pc
    apb_access(1'b0, CSR_CTRL, '0, rd, rd_err);
    check_word("ctrl after reset", rd, 32'd1);
    apb_access(1'b0, CSR_BOOT_PC, '0, rd, rd_err);
    check_word("boot pc after reset", rd, RESET_PC);
    check_bit("pslverr after reset", rd_err, 1'b0);

    for (e = 0; e < trace_len; e++) begin
      base = TRACE_BASE + 5 * e;
      if (stim[base + 2][1:0] != 2'd0) begin
        while (!(hazards_seen > resolved_local)) @(posedge clk);
        for (k = 0; k < int'(stim[base + 4]); k++) begin
          run_apb_step(apb_ptr);
          apb_ptr++;
        end
        res = stim[base + 3];
        // 1 means a restart or the end of the trace took over
        if (res != 32'd1) begin
          repeat (e % 3 + 1) @(posedge clk);
          @(posedge clk);
          if (res == 32'd0) begin
            pc_retire_i <= 1'b1;
          end else begin
            pc_change_i <= 1'b1;
            npc_i <= res;
          end
          @(posedge clk);
          pc_retire_i <= 1'b0;
          pc_change_i <= 1'b0;
        end
        hazards_resolved <= hazards_resolved + 1;
        resolved_local++;
      end
    end

    while (seen_count < trace_len) @(posedge clk);
    repeat (20) @(posedge clk);
    check_word("apb steps run", 32'(apb_ptr), stim[1]);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/ifu_stimulus.mem ====
// header: trace length, apb step count; image at @10 (byte offset from 0x80000000)
// trace at @40: pc inst class(0 plain 1 ctrl 2 load 3 fence.i) res(0 retire 1 none) apb_n
@000
00000019 0000000f
@010
00100093 00200113 00002183 00312023
00108093 00210113 00318193 fe000ae3
0000100f 00400213 0000006f 00000013
00000013 00000013 00000013 00000013
00500293 00600313 0180006f 00700393
00800413 0000006f 00000013 00000013
00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013
@040
80000000 00100093 00000000 00000000 00000000
80000004 00200113 00000000 00000000 00000000
80000008 00002183 00000002 00000000 00000001
8000000c 00312023 00000000 00000000 00000000
80000010 00108093 00000000 00000000 00000000
80000014 00210113 00000000 00000000 00000000
80000018 00318193 00000000 00000000 00000000
8000001c fe000ae3 00000001 80000010 00000002
80000010 00108093 00000000 00000000 00000000
80000014 00210113 00000000 00000000 00000000
80000018 00318193 00000000 00000000 00000000
8000001c fe000ae3 00000001 80000020 00000002
80000020 0000100f 00000003 80000010 00000000
80000010 00108093 00000000 00000000 00000000
80000014 00210113 00000000 00000000 00000000
80000018 00318193 00000000 00000000 00000000
8000001c fe000ae3 00000001 80000024 00000001
80000024 00400213 00000000 00000000 00000000
80000028 0000006f 00000001 00000001 00000006
80000040 00500293 00000000 00000000 00000000
80000044 00600313 00000000 00000000 00000000
80000048 0180006f 00000001 00000000 00000003
8000004c 00700393 00000000 00000000 00000000
80000050 00800413 00000000 00000000 00000000
80000054 0000006f 00000001 00000001 00000000
// apb steps: flags(bit0 wr, bit1 slverr, bit2 check) addr wdata expected
@100
00000001 00000000 00000009 00000000
00000004 0000000c 00000000 00000002
00000004 00000008 00000000 00000005
00000004 0000000c 00000000 00000002
00000004 00000008 00000000 00000009
00000004 0000000c 00000000 00000006
00000001 00000004 80000040 00000000
00000004 00000004 00000000 80000040
00000002 00000010 00000000 00000000
00000003 00000008 00000001 00000000
00000001 00000000 00000008 00000000
00000001 00000000 00000004 00000000
00000004 00000008 00000000 00000000
00000004 0000000c 00000000 00000003
00000001 00000000 00000001 00000000

// ==== ifu_top.f ====
verilog/rv_isa_pkg.sv
verilog/l1i_pkg.sv
verilog/fetch_ctrl.sv
verilog/l1i_cache.sv
verilog/fetch_csr_apb.sv
verilog/ifu_top.sv
testbench/ifu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module ifu_tb --Mdir obj_dir -o ifu_sim -f ifu_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/ifu_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
  exit 0
fi
echo "pass message not found"
exit 1
